/* rtl/leaf_defines.svh */
`ifndef LEAF_DEFINES_SVH
`define LEAF_DEFINES_SVH

// Tree packet layout, from the top bit down: valid, leaf, port, addr, payload.
`define LEAF_PACKET_BITS 49
`define LEAF_PAYLOAD_BITS 32
`define LEAF_LEAF_BITS 5
`define LEAF_PORT_BITS 4
`define LEAF_ADDR_BITS 7

// Entries per queue, payload and output queues alike.
`define LEAF_FIFO_DEPTH 8

// Port 0 is the configuration port and is not counted here.
`define LEAF_NUM_IN_PORTS 3

`endif

/* rtl/bft_pkg.sv */
`include "leaf_defines.svh"

package bft_pkg;

    typedef logic [`LEAF_LEAF_BITS-1:0] leaf_id_t;
    typedef logic [`LEAF_PORT_BITS-1:0] port_id_t;

    // Packet as it travels through the tree.
    typedef struct packed {
        logic valid;
        leaf_id_t dest_leaf;
        port_id_t dest_port;
        logic [`LEAF_ADDR_BITS-1:0] addr; // BRAM address, passed along untouched.
        logic [`LEAF_PAYLOAD_BITS-1:0] payload;
    } bft_packet_t;

endpackage

/* rtl/leaf_pkg.sv */
`include "leaf_defines.svh"

package leaf_pkg;

    // Word exchanged with the user kernel.
    typedef logic [`LEAF_PAYLOAD_BITS-1:0] word_t;

    // Where the leaf sends its output packets.
    typedef struct packed {
        bft_pkg::leaf_id_t dest_leaf;
        bft_pkg::port_id_t dest_port;
    } dest_cfg_t;

endpackage

/* rtl/stream_if.sv */
`timescale 1ns/1ps
`include "leaf_defines.svh"

interface stream_if #(
    parameter type data_t = logic [`LEAF_PAYLOAD_BITS-1:0]
);

    data_t data;
    logic vld;
    logic ack; // A word moves in every cycle with vld and ack both high.

    modport producer (
        output data,
        output vld,
        input ack
    );

    modport consumer (
        input data,
        input vld,
        output ack
    );

endinterface

/* rtl/port_fifo.sv */
`timescale 1ns/1ps

module port_fifo #(
    parameter type entry_t = logic [31:0],
    parameter int depth = 8
) (
    input logic clk,
    input logic arst_n,
    stream_if.consumer wr,
    stream_if.producer rd
);

    localparam int ptr_bits = $clog2(depth);
    localparam logic [ptr_bits-1:0] last_idx = ptr_bits'(depth - 1);
    localparam logic [ptr_bits:0] full_count = (ptr_bits + 1)'(depth);

    entry_t mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0] count;
    logic push;
    logic pop;

    assign wr.ack = (count != full_count);
    assign rd.vld = (count != '0);
    assign rd.data = mem[rd_ptr]; // Head entry stays put until it is popped.

    assign push = wr.vld && wr.ack;
    assign pop = rd.vld && rd.ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.data;
        end
    end

endmodule

/* rtl/pkt_router_in.sv */
`timescale 1ns/1ps
`include "leaf_defines.svh"

module pkt_router_in #(
    parameter bft_pkg::leaf_id_t leaf_id = 5'd3
) (
    input logic clk,
    input logic arst_n,
    input bft_pkg::bft_packet_t din_leaf_bft2interface,
    stream_if.producer port_out [1:`LEAF_NUM_IN_PORTS],
    output logic cfg_wr,
    output leaf_pkg::dest_cfg_t cfg_data
);

    import bft_pkg::*;
    import leaf_pkg::*;

    logic hit;
    logic [`LEAF_NUM_IN_PORTS:1] vld_q;
    word_t payload_q;

    assign hit = din_leaf_bft2interface.valid && (din_leaf_bft2interface.dest_leaf == leaf_id);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
            cfg_wr <= 1'b0;
        end else begin
            vld_q <= '0;
            cfg_wr <= 1'b0;
            if (hit) begin
                if (din_leaf_bft2interface.dest_port == '0) begin
                    cfg_wr <= 1'b1;
                end
                // Ports beyond the last input port fall through and are dropped.
                for (int p = 1; p <= `LEAF_NUM_IN_PORTS; p++) begin
                    if (din_leaf_bft2interface.dest_port == port_id_t'(p)) begin
                        vld_q[p] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            payload_q <= din_leaf_bft2interface.payload;
            cfg_data.dest_leaf <= din_leaf_bft2interface.payload[`LEAF_LEAF_BITS-1:0];
            cfg_data.dest_port <= din_leaf_bft2interface.payload[`LEAF_LEAF_BITS +: `LEAF_PORT_BITS];
        end
    end

    // A full queue leaves ack low and the word is lost.
    for (genvar p = 1; p <= `LEAF_NUM_IN_PORTS; p++) begin : g_port
        assign port_out[p].vld = vld_q[p];
        assign port_out[p].data = payload_q;
    end

endmodule

/* rtl/user_kernel.sv */
`timescale 1ns/1ps

module user_kernel (
    input logic clk,
    input logic arst_n,
    input logic user_rst,
    stream_if.consumer in1,
    stream_if.consumer in2,
    stream_if.consumer in3,
    stream_if.producer out
);

    import leaf_pkg::*;

    logic take;
    logic sum_vld;
    word_t sum_q;

    // All three words are taken together, and only when the result has somewhere to go.
    assign take = !user_rst && in1.vld && in2.vld && in3.vld && (!sum_vld || out.ack);

    assign in1.ack = take;
    assign in2.ack = take;
    assign in3.ack = take;

    assign out.vld = sum_vld;
    assign out.data = sum_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_vld <= 1'b0;
        end else if (user_rst) begin
            sum_vld <= 1'b0;
        end else if (take) begin
            sum_vld <= 1'b1;
        end else if (out.ack) begin
            sum_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (user_rst) begin
            sum_q <= '0;
        end else if (take) begin
            sum_q <= in1.data + in2.data + in3.data; // Wraps at 32 bits.
        end
    end

endmodule

/* rtl/leaf_ctrl.sv */
`timescale 1ns/1ps

module leaf_ctrl (
    input logic clk,
    input logic arst_n,
    input logic ap_start,
    input logic resend,
    input logic cfg_wr,
    input leaf_pkg::dest_cfg_t cfg_data,
    output logic user_rst,
    stream_if.consumer k_out,
    stream_if.producer pkt_q_in,
    stream_if.consumer pkt_q_out,
    output bft_pkg::bft_packet_t dout_leaf_interface2bft
);

    import bft_pkg::*;
    import leaf_pkg::*;

    logic started;
    dest_cfg_t dest_q;
    logic wrap_vld;
    bft_packet_t wrap_pkt;
    bft_packet_t out_pkt;

    assign user_rst = !started; // Kernel stays in reset until the first ap_start.

    assign k_out.ack = !wrap_vld || pkt_q_in.ack;
    assign pkt_q_in.vld = wrap_vld;
    assign pkt_q_in.data = wrap_pkt;

    assign pkt_q_out.ack = !resend;

    // A packet hidden by resend is still held in out_pkt and goes out once resend drops.
    assign dout_leaf_interface2bft = resend ? '0 : out_pkt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
            dest_q <= '0;
            wrap_vld <= 1'b0;
            out_pkt <= '0;
        end else begin
            if (ap_start) begin
                started <= 1'b1;
            end
            if (cfg_wr) begin
                dest_q <= cfg_data;
            end
            if (k_out.vld && k_out.ack) begin
                wrap_vld <= 1'b1;
            end else if (pkt_q_in.ack) begin
                wrap_vld <= 1'b0;
            end
            if (!resend) begin
                out_pkt <= pkt_q_out.vld ? pkt_q_out.data : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (k_out.vld && k_out.ack) begin
            wrap_pkt.valid <= 1'b1;
            wrap_pkt.dest_leaf <= dest_q.dest_leaf;
            wrap_pkt.dest_port <= dest_q.dest_port;
            wrap_pkt.addr <= '0;
            wrap_pkt.payload <= k_out.data;
        end
    end

endmodule

/* rtl/leaf_i3o1.sv */
`timescale 1ns/1ps
`include "leaf_defines.svh"

module leaf_i3o1 #(
    parameter bft_pkg::leaf_id_t leaf_id = 5'd3
) (
    input logic clk,
    input logic arst_n,
    input logic [`LEAF_PACKET_BITS-1:0] din_leaf_bft2interface,
    output logic [`LEAF_PACKET_BITS-1:0] dout_leaf_interface2bft,
    input logic resend,
    input logic ap_start
);

    import bft_pkg::*;
    import leaf_pkg::*;

    logic cfg_wr;
    dest_cfg_t cfg_data;
    logic user_rst;

    stream_if #(.data_t(word_t)) in_q [1:`LEAF_NUM_IN_PORTS] ();
    stream_if #(.data_t(word_t)) k_in [1:`LEAF_NUM_IN_PORTS] ();
    stream_if #(.data_t(word_t)) k_out ();
    stream_if #(.data_t(bft_packet_t)) pkt_q_in ();
    stream_if #(.data_t(bft_packet_t)) pkt_q_out ();

    pkt_router_in #(
        .leaf_id(leaf_id)
    ) pkt_router_in_inst (
        .clk(clk),
        .arst_n(arst_n),
        .din_leaf_bft2interface(bft_packet_t'(din_leaf_bft2interface)),
        .port_out(in_q),
        .cfg_wr(cfg_wr),
        .cfg_data(cfg_data)
    );

    for (genvar p = 1; p <= `LEAF_NUM_IN_PORTS; p++) begin : g_in_fifo
        port_fifo #(
            .entry_t(word_t),
            .depth(`LEAF_FIFO_DEPTH)
        ) port_fifo_inst (
            .clk(clk),
            .arst_n(arst_n),
            .wr(in_q[p]),
            .rd(k_in[p])
        );
    end

    user_kernel user_kernel_inst (
        .clk(clk),
        .arst_n(arst_n),
        .user_rst(user_rst),
        .in1(k_in[1]),
        .in2(k_in[2]),
        .in3(k_in[3]),
        .out(k_out)
    );

    port_fifo #(
        .entry_t(bft_packet_t),
        .depth(`LEAF_FIFO_DEPTH)
    ) out_fifo_inst (
        .clk(clk),
        .arst_n(arst_n),
        .wr(pkt_q_in),
        .rd(pkt_q_out)
    );

    leaf_ctrl leaf_ctrl_inst (
        .clk(clk),
        .arst_n(arst_n),
        .ap_start(ap_start),
        .resend(resend),
        .cfg_wr(cfg_wr),
        .cfg_data(cfg_data),
        .user_rst(user_rst),
        .k_out(k_out),
        .pkt_q_in(pkt_q_in),
        .pkt_q_out(pkt_q_out),
        .dout_leaf_interface2bft(dout_leaf_interface2bft)
    );

endmodule

/* verif/leaf_asserts.sv */
`timescale 1ns/1ps
`include "leaf_defines.svh"

module leaf_asserts (
    input logic clk,
    input logic arst_n,
    input logic resend,
    input logic [`LEAF_PACKET_BITS-1:0] dout,
    input logic q_vld,
    input logic q_ack,
    input logic [`LEAF_PACKET_BITS-1:0] q_data,
    input logic [`LEAF_NUM_IN_PORTS-1:0] in_vld,
    input logic [`LEAF_NUM_IN_PORTS-1:0] in_ack
);

    a_resend_zero: assert property (@(posedge clk) disable iff (!arst_n)
        resend |-> dout == '0)
        else $error("Output bus is not zero while resend is high");

    // Output queue head must hold while it waits for an ack.
    a_q_stable: assert property (@(posedge clk) disable iff (!arst_n)
        q_vld && !q_ack |=> $stable(q_data))
        else $error("Output queue data changed while vld was high and ack low");

    a_no_drop: assert property (@(posedge clk) disable iff (!arst_n)
        (in_vld & ~in_ack) == '0)
        else $error("Router wrote a payload into a full queue");

endmodule

bind leaf_i3o1 leaf_asserts leaf_asserts_inst (
    .clk(clk),
    .arst_n(arst_n),
    .resend(resend),
    .dout(dout_leaf_interface2bft),
    .q_vld(pkt_q_out.vld),
    .q_ack(pkt_q_out.ack),
    .q_data(pkt_q_out.data),
    .in_vld({in_q[3].vld, in_q[2].vld, in_q[1].vld}),
    .in_ack({in_q[3].ack, in_q[2].ack, in_q[1].ack})
);

/* verif/leaf_tb.sv */
`timescale 1ns/1ps
`include "leaf_defines.svh"

module leaf_tb;

    import bft_pkg::*;

    localparam leaf_id_t leaf_id = 5'd3;
    localparam int pkt_bits = `LEAF_PACKET_BITS;
    localparam int drain_timeout = 200;
    localparam int settle_cycles = 20;

    logic clk;
    logic arst_n;
    logic [`LEAF_PACKET_BITS-1:0] din;
    logic [`LEAF_PACKET_BITS-1:0] dout;
    logic resend;
    logic ap_start;

    logic [`LEAF_PACKET_BITS-1:0] expect_q [$]; // Output packets still to come, in order.
    int errors;
    int checks;
    int fd;

    leaf_i3o1 #(
        .leaf_id(leaf_id)
    ) leaf_i3o1_inst (
        .clk(clk),
        .arst_n(arst_n),
        .din_leaf_bft2interface(din),
        .dout_leaf_interface2bft(dout),
        .resend(resend),
        .ap_start(ap_start)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string what, input logic [`LEAF_PACKET_BITS-1:0] got,
                               input logic [`LEAF_PACKET_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_cycle(input logic [`LEAF_PACKET_BITS-1:0] pkt, input logic rs,
                               input logic st);
        @(posedge clk);
        din <= pkt;
        resend <= rs;
        ap_start <= st;
    endtask

    // Idles the inputs until every expected packet has been seen.
    task automatic wait_drained(input string why);
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < drain_timeout) begin
            drive_cycle('0, 1'b0, 1'b0);
            waited++;
        end
        if (expect_q.size() != 0) begin
            errors++;
            $display("Timeout at %0t ns: %0d expected packets never came out (%s)",
                     $time, expect_q.size(), why);
        end
    endtask

    task automatic run_stimulus();
        string line;
        byte cmd;
        logic [31:0] field [4];
        int n;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 1) begin
                continue;
            end
            cmd = line.getc(0);
            for (int i = 0; i < 4; i++) begin
                field[i] = '0;
            end
            if (line.len() > 1) begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                            field[0], field[1], field[2], field[3]);
            end
            case (cmd)
                "P": begin
                    // A new destination only applies cleanly once nothing is in flight.
                    if (field[0][4:0] == leaf_id && field[1][3:0] == 4'd0) begin
                        wait_drained("before a configuration packet");
                    end
                    drive_cycle({1'b1, field[0][4:0], field[1][3:0], field[2][6:0], field[3]},
                                1'b0, 1'b0);
                end
                "R": repeat (field[0]) drive_cycle('0, 1'b1, 1'b0);
                "S": begin
                    // Words already wait on all ports, so a kernel running early shows up here.
                    repeat (settle_cycles) drive_cycle('0, 1'b0, 1'b0);
                    drive_cycle('0, 1'b0, 1'b1);
                end
                "E": expect_q.push_back({1'b1, field[0][4:0], field[1][3:0], 7'd0, field[2]});
                "#", "\n", "\r", " ": ;
                default: begin
                    errors++;
                    $display("Unknown command in stimulus file: %s", line);
                end
            endcase
        end
    endtask

    // Outputs are sampled on the falling edge, away from the driving edge.
    always @(negedge clk) begin
        if (arst_n) begin
            if (resend) begin
                check_value("output during resend", dout, '0);
            end
            if (dout[`LEAF_PACKET_BITS-1]) begin
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("Unexpected output packet %h at %0t ns", dout, $time);
                end else begin
                    check_value("output packet", dout, expect_q.pop_front());
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        din = '0;
        resend = 1'b0;
        ap_start = 1'b0;
        errors = 0;
        checks = 0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen("verif/leaf_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file verif/leaf_stimulus.txt");
        end else begin
            run_stimulus();
            $fclose(fd);
            drive_cycle('0, 1'b0, 1'b0);
            wait_drained("at the end of the stimulus");
            repeat (settle_cycles) drive_cycle('0, 1'b0, 1'b0); // Catches stray packets.
            check_value("packets left unseen", pkt_bits'(expect_q.size()), '0);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verif/leaf_stimulus.txt */
# P leaf port addr payload : drive one tree packet for a cycle (hex fields)
# R cycles : hold resend high; S : pulse ap_start; E leaf port payload : expected output (hex)
P 03 1 00 00000011
P 07 2 00 0000dead
P 03 2 00 00000022
P 03 5 00 00000777
P 03 3 05 00000033
P 04 1 00 00000099
P 01 3 00 12345678
S
E 00 0 00000066
P 03 0 00 00000045
P 06 0 00 0000001f
E 05 2 00000004
E 05 2 00000600
E 05 2 00000003
E 05 2 00000060
P 03 1 00 ffffffff
P 03 1 00 00000100
P 03 1 00 00000001
P 03 2 00 00000002
P 03 2 00 00000200
P 03 2 00 00000001
P 03 3 00 00000003
P 03 3 00 00000300
P 03 3 00 00000001
R 8
P 03 1 00 00000010
P 03 2 00 00000020
P 03 3 00 00000030

/* files.f */
+incdir+rtl
rtl/bft_pkg.sv
rtl/leaf_pkg.sv
rtl/stream_if.sv
rtl/port_fifo.sv
rtl/pkt_router_in.sv
rtl/user_kernel.sv
rtl/leaf_ctrl.sv
rtl/leaf_i3o1.sv
verif/leaf_asserts.sv
verif/leaf_tb.sv

/* run.sh */
#!/bin/sh
# Builds the leaf testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module leaf_tb -o leaf_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/leaf_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q 'All tests passed!' sim.log; then
    exit 0
fi
exit 1
